//--- soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Each RAM holds 2**RAM_ADDR_W words
`define RAM_ADDR_W 10
`define RAM_ALIGN  2

// Region codes in address bits 31..24
`define IRAM_REGION  8'h02
`define DRAM_REGION  8'h00
`define EXT_REGION_A 8'h0E
`define EXT_REGION_B 8'h0F

`endif

//--- soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

    // ------------------------------------------------------------------
    // OBI
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                     req;
        logic [`SOC_ADDR_W-1:0]   addr;
    } obi_fetch_req_t;

    typedef struct packed {
        logic                     req;
        logic [`SOC_ADDR_W-1:0]   addr;
        logic                     we;
        logic [`SOC_DATA_W/8-1:0] be;
        logic [`SOC_DATA_W-1:0]   wdata;
    } obi_req_t;

    typedef struct packed {
        logic                     gnt;
        logic                     rvalid;
        logic [`SOC_DATA_W-1:0]   rdata;
    } obi_rsp_t;

    // ------------------------------------------------------------------
    // Wishbone classic
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0]   adr;
        logic [`SOC_DATA_W-1:0]   dat;
        logic                     we;
        logic [`SOC_DATA_W/8-1:0] sel;
        logic                     stb;
        logic                     cyc;
    } wb_m2s_t;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0]   dat;
        logic                     ack;
    } wb_s2m_t;

    // Target of the current bus address
    typedef enum logic [2:0] {
        REG_IRAM,
        REG_DRAM,
        REG_EXT,
        REG_NONE
    } region_e;

endpackage

//--- obi_arbiter.sv
`timescale 1ns/1ps

module obi_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  soc_pkg::obi_fetch_req_t fetch_req_i,
    output soc_pkg::obi_rsp_t       fetch_rsp_o,
    input  soc_pkg::obi_req_t       data_req_i,
    output soc_pkg::obi_rsp_t       data_rsp_o,
    output soc_pkg::obi_req_t       bus_req_o,
    input  soc_pkg::obi_rsp_t       bus_rsp_i
);

    logic busy_q;
    logic owner_data_q;
    logic sel_data;

    // Data port wins when idle, owner frozen while busy
    assign sel_data = busy_q ? owner_data_q : data_req_i.req;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q       <= 1'b0;
            owner_data_q <= 1'b0;
        end else if (!busy_q) begin
            busy_q       <= data_req_i.req || fetch_req_i.req;
            owner_data_q <= data_req_i.req;
        end else if (bus_rsp_i.rvalid) begin
            busy_q <= 1'b0;
        end
    end

    // Fetch becomes a full word read
    always_comb begin
        if (sel_data) begin
            bus_req_o = data_req_i;
        end else begin
            bus_req_o.req   = fetch_req_i.req;
            bus_req_o.addr  = fetch_req_i.addr;
            bus_req_o.we    = 1'b0;
            bus_req_o.be    = '1;
            bus_req_o.wdata = '0;
        end
    end

    // Responses go back to the owner only
    always_comb begin
        fetch_rsp_o.gnt    = bus_rsp_i.gnt && !sel_data;
        fetch_rsp_o.rvalid = bus_rsp_i.rvalid && !sel_data;
        fetch_rsp_o.rdata  = sel_data ? '0 : bus_rsp_i.rdata;
        data_rsp_o.gnt     = bus_rsp_i.gnt && sel_data;
        data_rsp_o.rvalid  = bus_rsp_i.rvalid && sel_data;
        data_rsp_o.rdata   = sel_data ? bus_rsp_i.rdata : '0;
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(fetch_rsp_o.gnt && data_rsp_o.gnt))
        else $error("fetch and data granted in the same cycle");

endmodule

//--- soc_interconnect.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_interconnect (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  soc_pkg::obi_req_t        bus_req_i,
    output soc_pkg::obi_rsp_t        bus_rsp_o,
    output soc_pkg::obi_req_t        ext_req_o,
    input  soc_pkg::obi_rsp_t        ext_rsp_i,
    output logic [`RAM_ADDR_W-1:0]   iram_addr_o,
    output logic                     iram_we_o,
    output logic [`SOC_DATA_W/8-1:0] iram_be_o,
    output logic [`SOC_DATA_W-1:0]   iram_wdata_o,
    input  logic [`SOC_DATA_W-1:0]   iram_rdata_i,
    output logic [`RAM_ADDR_W-1:0]   dram_addr_o,
    output logic                     dram_we_o,
    output logic [`SOC_DATA_W/8-1:0] dram_be_o,
    output logic [`SOC_DATA_W-1:0]   dram_wdata_o,
    input  logic [`SOC_DATA_W-1:0]   dram_rdata_i
);
    import soc_pkg::*;

    localparam int WORD_LSB = `RAM_ALIGN;
    localparam int WORD_MSB = `RAM_ADDR_W + `RAM_ALIGN - 1;

    region_e                region;
    region_e                region_q;
    logic                   ram_gnt_q;
    logic                   ram_rvalid_q;
    logic                   gnt;
    logic                   rvalid;
    logic [`SOC_DATA_W-1:0] rdata;

    // ------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------
    always_comb begin
        case (bus_req_i.addr[`SOC_ADDR_W-1 -: 8])
            `IRAM_REGION:                 region = REG_IRAM;
            `DRAM_REGION:                 region = REG_DRAM;
            `EXT_REGION_A, `EXT_REGION_B: region = REG_EXT;
            default:                      region = REG_NONE;
        endcase
    end

    // ------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------
    assign gnt    = ram_gnt_q | ext_rsp_i.gnt;
    assign rvalid = ram_rvalid_q | ext_rsp_i.rvalid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ram_gnt_q    <= 1'b0;
            ram_rvalid_q <= 1'b0;
            region_q     <= REG_NONE;
        end else begin
            // Unmapped regions complete like a RAM
            ram_gnt_q    <= bus_req_i.req && (region != REG_EXT) && !gnt && !rvalid;
            ram_rvalid_q <= ram_gnt_q;
            if (gnt) begin
                region_q <= region;
            end
        end
    end

    always_comb begin
        ext_req_o     = bus_req_i;
        ext_req_o.req = bus_req_i.req && (region == REG_EXT) && !gnt && !rvalid;
    end

    // RAM write lands on the edge closing the gnt cycle
    assign iram_addr_o  = bus_req_i.addr[WORD_MSB:WORD_LSB];
    assign iram_we_o    = ram_gnt_q && bus_req_i.we && (region == REG_IRAM);
    assign iram_be_o    = bus_req_i.be;
    assign iram_wdata_o = bus_req_i.wdata;
    assign dram_addr_o  = bus_req_i.addr[WORD_MSB:WORD_LSB];
    assign dram_we_o    = ram_gnt_q && bus_req_i.we && (region == REG_DRAM);
    assign dram_be_o    = bus_req_i.be;
    assign dram_wdata_o = bus_req_i.wdata;

    // Read data follows the region seen at gnt
    always_comb begin
        case (region_q)
            REG_IRAM: rdata = iram_rdata_i;
            REG_DRAM: rdata = dram_rdata_i;
            REG_EXT:  rdata = ext_rsp_i.rdata;
            default:  rdata = '0;
        endcase
    end

    assign bus_rsp_o.gnt    = gnt;
    assign bus_rsp_o.rvalid = rvalid;
    assign bus_rsp_o.rdata  = rdata;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid |-> $past(gnt))
        else $error("rvalid without gnt in the previous cycle");

endmodule

//--- sram_dualport.sv
`timescale 1ns/1ps

module sram_dualport #(
    parameter int DEPTH = 1024,
    parameter int WIDTH = 32
) (
    input  logic                     clk_i,
    input  logic [$clog2(DEPTH)-1:0] addr_a_i,
    input  logic                     we_a_i,
    input  logic [WIDTH/8-1:0]       be_a_i,
    input  logic [WIDTH-1:0]         d_a_i,
    output logic [WIDTH-1:0]         q_a_o,
    input  logic [$clog2(DEPTH)-1:0] addr_b_i,
    input  logic                     we_b_i,
    input  logic [WIDTH-1:0]         d_b_i,
    output logic [WIDTH-1:0]         q_b_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
        // Port A byte lanes
        for (int i = 0; i < WIDTH/8; i++) begin
            if (we_a_i && be_a_i[i]) begin
                mem[addr_a_i][i*8 +: 8] <= d_a_i[i*8 +: 8];
            end
        end
        // Port B whole word, wins on a collision
        if (we_b_i) begin
            mem[addr_b_i] <= d_b_i;
        end
        q_a_o <= mem[addr_a_i];
        q_b_o <= mem[addr_b_i];
    end

endmodule

//--- obi_wb_bridge.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module obi_wb_bridge (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  soc_pkg::obi_req_t ext_req_i,
    output soc_pkg::obi_rsp_t ext_rsp_o,
    output soc_pkg::wb_m2s_t  wb_o,
    input  soc_pkg::wb_s2m_t  wb_i
);

    typedef enum logic {IDLE, CYCLE} state_e;

    state_e                   state_q;
    logic                     cyc_q;
    logic                     stb_q;
    logic                     gnt_q;
    logic                     rvalid_q;
    logic                     start;
    logic                     done;
    logic [`SOC_ADDR_W-1:0]   adr_q;
    logic [`SOC_DATA_W-1:0]   dat_q;
    logic                     we_q;
    logic [`SOC_DATA_W/8-1:0] sel_q;
    logic [`SOC_DATA_W-1:0]   rdata_q;

    // No new cycle until the previous rvalid has gone out
    assign start = (state_q == IDLE) && ext_req_i.req && !gnt_q && !rvalid_q;
    assign done  = (state_q == CYCLE) && wb_i.ack;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            cyc_q    <= 1'b0;
            stb_q    <= 1'b0;
            gnt_q    <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            gnt_q    <= done;
            rvalid_q <= gnt_q;
            if (start) begin
                state_q <= CYCLE;
                cyc_q   <= 1'b1;
                stb_q   <= 1'b1;
            end else if (done) begin
                state_q <= IDLE;
                cyc_q   <= 1'b0;
                stb_q   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_q <= ext_req_i.addr;
            dat_q <= ext_req_i.wdata;
            we_q  <= ext_req_i.we;
            sel_q <= ext_req_i.be;
        end
        if (done) begin
            rdata_q <= wb_i.dat;
        end
    end

    assign wb_o.adr = adr_q;
    assign wb_o.dat = dat_q;
    assign wb_o.we  = we_q;
    assign wb_o.sel = sel_q;
    assign wb_o.stb = stb_q;
    assign wb_o.cyc = cyc_q;

    assign ext_rsp_o.gnt    = gnt_q;
    assign ext_rsp_o.rvalid = rvalid_q;
    assign ext_rsp_o.rdata  = rdata_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_o.stb |-> wb_o.cyc)
        else $error("stb high without cyc");

endmodule

//--- wb_ram_port.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module wb_ram_port (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  soc_pkg::wb_m2s_t       host_wb_i,
    output soc_pkg::wb_s2m_t       host_wb_o,
    output logic [`RAM_ADDR_W-1:0] ram_addr_o,
    output logic [`SOC_DATA_W-1:0] ram_wdata_o,
    output logic                   iram_we_o,
    output logic                   dram_we_o,
    input  logic [`SOC_DATA_W-1:0] iram_rdata_i,
    input  logic [`SOC_DATA_W-1:0] dram_rdata_i
);

    logic [1:0] cnt_q;
    logic       start;
    logic       hit_iram;
    logic       hit_dram;

    assign hit_iram = host_wb_i.adr[`SOC_ADDR_W-1 -: 8] == `IRAM_REGION;
    assign hit_dram = host_wb_i.adr[`SOC_ADDR_W-1 -: 8] == `DRAM_REGION;
    assign start    = host_wb_i.cyc && host_wb_i.stb && (cnt_q == 2'd0);

    // 0 idle, 1 RAM read, 2 ack
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= 2'd0;
        end else begin
            case (cnt_q)
                2'd0:    cnt_q <= start ? 2'd1 : 2'd0;
                2'd1:    cnt_q <= 2'd2;
                default: cnt_q <= 2'd0;
            endcase
        end
    end

    // Writes go out in the first cycle only
    assign ram_addr_o  = host_wb_i.adr[`RAM_ADDR_W+`RAM_ALIGN-1:`RAM_ALIGN];
    assign ram_wdata_o = host_wb_i.dat;
    assign iram_we_o   = start && host_wb_i.we && hit_iram;
    assign dram_we_o   = start && host_wb_i.we && hit_dram;

    assign host_wb_o.ack = (cnt_q == 2'd2);
    assign host_wb_o.dat = hit_iram ? iram_rdata_i :
                           hit_dram ? dram_rdata_i : '0;

endmodule

//--- soc_fabric.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_fabric (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  soc_pkg::obi_fetch_req_t fetch_req_i,
    output soc_pkg::obi_rsp_t       fetch_rsp_o,
    input  soc_pkg::obi_req_t       data_req_i,
    output soc_pkg::obi_rsp_t       data_rsp_o,
    output soc_pkg::wb_m2s_t        ext_wb_o,
    input  soc_pkg::wb_s2m_t        ext_wb_i,
    input  soc_pkg::wb_m2s_t        host_wb_i,
    output soc_pkg::wb_s2m_t        host_wb_o
);
    import soc_pkg::*;

    localparam int RAM_DEPTH = 1 << `RAM_ADDR_W;

    obi_req_t                 bus_req;
    obi_rsp_t                 bus_rsp;
    obi_req_t                 ext_req;
    obi_rsp_t                 ext_rsp;

    // Port A side of both RAMs
    logic [`RAM_ADDR_W-1:0]   iram_addr;
    logic                     iram_we;
    logic [`SOC_DATA_W/8-1:0] iram_be;
    logic [`SOC_DATA_W-1:0]   iram_wdata;
    logic [`SOC_DATA_W-1:0]   iram_rdata;
    logic [`RAM_ADDR_W-1:0]   dram_addr;
    logic                     dram_we;
    logic [`SOC_DATA_W/8-1:0] dram_be;
    logic [`SOC_DATA_W-1:0]   dram_wdata;
    logic [`SOC_DATA_W-1:0]   dram_rdata;

    // Port B side, shared by the host port
    logic [`RAM_ADDR_W-1:0]   host_addr;
    logic [`SOC_DATA_W-1:0]   host_wdata;
    logic                     host_iram_we;
    logic                     host_dram_we;
    logic [`SOC_DATA_W-1:0]   host_iram_rdata;
    logic [`SOC_DATA_W-1:0]   host_dram_rdata;

    obi_arbiter u_obi_arbiter (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .fetch_req_i (fetch_req_i),
        .fetch_rsp_o (fetch_rsp_o),
        .data_req_i  (data_req_i),
        .data_rsp_o  (data_rsp_o),
        .bus_req_o   (bus_req),
        .bus_rsp_i   (bus_rsp)
    );

    soc_interconnect u_soc_interconnect (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .bus_req_i    (bus_req),
        .bus_rsp_o    (bus_rsp),
        .ext_req_o    (ext_req),
        .ext_rsp_i    (ext_rsp),
        .iram_addr_o  (iram_addr),
        .iram_we_o    (iram_we),
        .iram_be_o    (iram_be),
        .iram_wdata_o (iram_wdata),
        .iram_rdata_i (iram_rdata),
        .dram_addr_o  (dram_addr),
        .dram_we_o    (dram_we),
        .dram_be_o    (dram_be),
        .dram_wdata_o (dram_wdata),
        .dram_rdata_i (dram_rdata)
    );

    sram_dualport #(
        .DEPTH (RAM_DEPTH),
        .WIDTH (`SOC_DATA_W)
    ) u_iram (
        .clk_i    (clk_i),
        .addr_a_i (iram_addr),
        .we_a_i   (iram_we),
        .be_a_i   (iram_be),
        .d_a_i    (iram_wdata),
        .q_a_o    (iram_rdata),
        .addr_b_i (host_addr),
        .we_b_i   (host_iram_we),
        .d_b_i    (host_wdata),
        .q_b_o    (host_iram_rdata)
    );

    sram_dualport #(
        .DEPTH (RAM_DEPTH),
        .WIDTH (`SOC_DATA_W)
    ) u_dram (
        .clk_i    (clk_i),
        .addr_a_i (dram_addr),
        .we_a_i   (dram_we),
        .be_a_i   (dram_be),
        .d_a_i    (dram_wdata),
        .q_a_o    (dram_rdata),
        .addr_b_i (host_addr),
        .we_b_i   (host_dram_we),
        .d_b_i    (host_wdata),
        .q_b_o    (host_dram_rdata)
    );

    obi_wb_bridge u_obi_wb_bridge (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .ext_req_i (ext_req),
        .ext_rsp_o (ext_rsp),
        .wb_o      (ext_wb_o),
        .wb_i      (ext_wb_i)
    );

    wb_ram_port u_wb_ram_port (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .host_wb_i    (host_wb_i),
        .host_wb_o    (host_wb_o),
        .ram_addr_o   (host_addr),
        .ram_wdata_o  (host_wdata),
        .iram_we_o    (host_iram_we),
        .dram_we_o    (host_dram_we),
        .iram_rdata_i (host_iram_rdata),
        .dram_rdata_i (host_dram_rdata)
    );

endmodule

//--- tb_soc_fabric.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc_fabric;
    import soc_pkg::*;

    localparam int N_WORDS   = 8;
    // Transactions issued by all tests together
    localparam int NUM_TRANS = 11 * N_WORDS + 5;
    localparam int RST_CYC   = 5;

    logic           clk_i;
    logic           rst_ni;
    obi_fetch_req_t fetch_req;
    obi_rsp_t       fetch_rsp;
    obi_req_t       data_req;
    obi_rsp_t       data_rsp;
    wb_m2s_t        ext_wb_o;
    wb_s2m_t        ext_wb_i;
    wb_m2s_t        host_wb_i;
    wb_s2m_t        host_wb_o;

    // Expected values and flags read by the assertions
    logic        rst_seen;
    logic        data_busy;
    logic        chk_data;
    logic [31:0] exp_data;
    logic [31:0] exp_fetch;
    logic        chk_host;
    logic [31:0] exp_host;
    wb_m2s_t     exp_wb;

    logic [31:0] lfsr;
    logic [31:0] iram_sb [1024];
    logic [31:0] dram_sb [1024];
    logic [9:0]  iram_idx [N_WORDS];
    logic [9:0]  dram_idx [N_WORDS];

    soc_fabric u_soc_fabric (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .ext_wb_o    (ext_wb_o),
        .ext_wb_i    (ext_wb_i),
        .host_wb_i   (host_wb_i),
        .host_wb_o   (host_wb_o)
    );

    always #50 clk_i = ~clk_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_seen <= 1'b0;
        end else begin
            rst_seen <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] ram_addr(input logic [7:0] region, input logic [9:0] idx);
        return {region, 12'h0, idx, 2'b00};
    endfunction

    task automatic data_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                               input logic [31:0] wdata, input logic check,
                               input logic [31:0] expect_w);
        @(posedge clk_i);
        data_req.req   <= 1'b1;
        data_req.addr  <= addr;
        data_req.we    <= we;
        data_req.be    <= be;
        data_req.wdata <= wdata;
        chk_data       <= check;
        exp_data       <= expect_w;
        exp_wb.adr     <= addr;
        exp_wb.dat     <= wdata;
        exp_wb.we      <= we;
        exp_wb.sel     <= be;
        data_busy      <= 1'b1;
        do @(negedge clk_i); while (!data_rsp.gnt);
        @(posedge clk_i);
        data_req.req <= 1'b0;
        do @(negedge clk_i); while (!data_rsp.rvalid);
        data_busy <= 1'b0;
    endtask

    task automatic fetch_read(input logic [9:0] idx);
        @(posedge clk_i);
        fetch_req.req  <= 1'b1;
        fetch_req.addr <= ram_addr(`IRAM_REGION, idx);
        exp_fetch      <= iram_sb[idx];
        do @(negedge clk_i); while (!fetch_rsp.gnt);
        @(posedge clk_i);
        fetch_req.req <= 1'b0;
        do @(negedge clk_i); while (!fetch_rsp.rvalid);
    endtask

    task automatic host_access(input logic [31:0] addr, input logic we,
                               input logic [31:0] wdata, input logic check,
                               input logic [31:0] expect_w);
        @(posedge clk_i);
        host_wb_i.adr <= addr;
        host_wb_i.dat <= wdata;
        host_wb_i.we  <= we;
        host_wb_i.sel <= 4'hF;
        host_wb_i.cyc <= 1'b1;
        host_wb_i.stb <= 1'b1;
        chk_host      <= check;
        exp_host      <= expect_w;
        do @(negedge clk_i); while (!host_wb_o.ack);
        @(posedge clk_i);
        host_wb_i.cyc <= 1'b0;
        host_wb_i.stb <= 1'b0;
        host_wb_i.we  <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // External Wishbone slave, ack after 0 to 3 cycles
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] d;
        forever begin
            @(negedge clk_i);
            if (ext_wb_o.cyc && ext_wb_o.stb) begin
                d = rand_bits(2);
                repeat (d) @(posedge clk_i);
                @(posedge clk_i);
                ext_wb_i.ack <= 1'b1;
                ext_wb_i.dat <= ~ext_wb_o.adr;
                @(posedge clk_i);
                ext_wb_i.ack <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------
    assert property (@(posedge clk_i) !rst_seen |-> !(fetch_rsp.gnt || fetch_rsp.rvalid ||
        data_rsp.gnt || data_rsp.rvalid || ext_wb_o.cyc || ext_wb_o.stb || host_wb_o.ack))
        else fail_now("handshake output high during or right after reset");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(data_req.req) && (data_req.addr[31:24] == `DRAM_REGION ||
        data_req.addr[31:24] == `IRAM_REGION || data_req.addr[31:24] == 8'h05)
        |-> ##1 data_rsp.gnt ##1 data_rsp.rvalid)
        else fail_now("data port RAM access without gnt and rvalid two cycles later");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rsp.rvalid && chk_data |-> data_rsp.rdata == exp_data)
        else fail_now($sformatf("** Error: data_rsp_o.rdata = %h, expected %h",
                                data_rsp.rdata, exp_data));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_rsp.rvalid |-> fetch_rsp.rdata == exp_fetch)
        else fail_now($sformatf("** Error: fetch_rsp_o.rdata = %h, expected %h",
                                fetch_rsp.rdata, exp_fetch));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_rsp.gnt |-> !data_busy)
        else fail_now("fetch granted while a data request was outstanding");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(host_wb_i.cyc) |-> ##2 host_wb_o.ack)
        else fail_now("host ack not two cycles after cyc");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        host_wb_o.ack && chk_host |-> host_wb_o.dat == exp_host)
        else fail_now($sformatf("** Error: host_wb_o.dat = %h, expected %h",
                                host_wb_o.dat, exp_host));

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ext_wb_o.cyc |-> ext_wb_o.adr == exp_wb.adr && ext_wb_o.we == exp_wb.we &&
        ext_wb_o.sel == exp_wb.sel && (!ext_wb_o.we || ext_wb_o.dat == exp_wb.dat))
        else fail_now($sformatf("** Error: ext_wb_o adr/dat/sel/we = %h/%h/%h/%h, expected %h/%h/%h/%h",
            ext_wb_o.adr, ext_wb_o.dat, ext_wb_o.sel, ext_wb_o.we,
            exp_wb.adr, exp_wb.dat, exp_wb.sel, exp_wb.we));

    // Back-pressure holds the cycle and the response
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ext_wb_o.cyc && !ext_wb_i.ack |=> ext_wb_o.cyc && ext_wb_o.stb && !data_rsp.rvalid)
        else fail_now("external cycle dropped or rvalid seen before ack");

    // ------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------
    initial begin
        #((NUM_TRANS * 20 + RST_CYC) * 100);
        fail_now("watchdog timeout, a handshake never completed");
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] w;
        logic [9:0]  idx;
        logic [3:0]  be;
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        lfsr      = 32'h3d16;
        fetch_req = '0;
        data_req  = '0;
        host_wb_i = '0;
        ext_wb_i  = '0;
        data_busy = 1'b0;
        chk_data  = 1'b0;
        exp_data  = '0;
        exp_fetch = '0;
        chk_host  = 1'b0;
        exp_host  = '0;
        exp_wb    = '0;
        repeat (RST_CYC) @(posedge clk_i);
        rst_ni <= 1'b1;

        // DRAM byte writes and read back
        for (int i = 0; i < N_WORDS; i++) begin
            r           = rand_bits(10);
            idx         = r[9:0];
            dram_idx[i] = idx;
            w           = rand_bits(32);
            dram_sb[idx] = w;
            data_access(ram_addr(`DRAM_REGION, idx), 1'b1, 4'hF, w, 1'b0, '0);
            for (int k = 0; k < 2; k++) begin
                r  = rand_bits(4);
                be = r[3:0];
                w  = rand_bits(32);
                dram_sb[idx] = merge_bytes(dram_sb[idx], w, be);
                data_access(ram_addr(`DRAM_REGION, idx), 1'b1, be, w, 1'b0, '0);
            end
            data_access(ram_addr(`DRAM_REGION, idx), 1'b0, 4'hF, '0, 1'b1, dram_sb[idx]);
        end

        // Host loads IRAM, fetch reads it, host reads DRAM
        for (int i = 0; i < N_WORDS; i++) begin
            r           = rand_bits(10);
            idx         = r[9:0];
            iram_idx[i] = idx;
            w           = rand_bits(32);
            iram_sb[idx] = w;
            host_access(ram_addr(`IRAM_REGION, idx), 1'b1, w, 1'b0, '0);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            fetch_read(iram_idx[i]);
            host_access(ram_addr(`DRAM_REGION, dram_idx[i]), 1'b0, '0, 1'b1,
                        dram_sb[dram_idx[i]]);
        end

        // External port writes and reads
        for (int i = 0; i < N_WORDS; i++) begin
            r  = rand_bits(24);
            w  = rand_bits(32);
            be = w[3:0] | 4'h1;
            data_access({`EXT_REGION_A, r[23:0]}, 1'b1, be, w, 1'b0, '0);
            r = rand_bits(22);
            w = {`EXT_REGION_B, r[21:0], 2'b00};
            data_access(w, 1'b0, 4'hF, '0, 1'b1, ~w);
        end

        // Simultaneous data and fetch requests
        for (int i = 0; i < N_WORDS; i++) begin
            fork
                data_access(ram_addr(`DRAM_REGION, dram_idx[i]), 1'b0, 4'hF, '0, 1'b1,
                            dram_sb[dram_idx[i]]);
                fetch_read(iram_idx[i]);
            join
        end

        // Unmapped region 0x05
        data_access(ram_addr(8'h05, dram_idx[0]), 1'b0, 4'hF, '0, 1'b1, '0);
        data_access(ram_addr(8'h05, dram_idx[0]), 1'b1, 4'hF, 32'hdeadbeef, 1'b0, '0);
        data_access(ram_addr(8'h05, iram_idx[0]), 1'b1, 4'hF, 32'h12345678, 1'b0, '0);
        data_access(ram_addr(`DRAM_REGION, dram_idx[0]), 1'b0, 4'hF, '0, 1'b1,
                    dram_sb[dram_idx[0]]);
        fetch_read(iram_idx[0]);

        repeat (4) @(posedge clk_i);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- soc_fabric.f
+incdir+.
soc_pkg.sv
obi_arbiter.sv
soc_interconnect.sv
sram_dualport.sv
obi_wb_bridge.sv
wb_ram_port.sv
soc_fabric.sv
tb_soc_fabric.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_fabric
FILELIST  ?= soc_fabric.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\*\* FAILED \*\*\*" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "\*\*\* PASSED \*\*\*" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
